// ==== src.f ====
cpu16_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
writeback_stage.sv
cpu16_top.sv
tb_checker.sv
tb_cpu16.sv

// ==== Makefile ====
# Verilator build and run for the 16-bit core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu16
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_cpu16.sv ====
// Testbench for the 16-bit core. Builds a program per test, predicts its stores
// with a reference model, and runs it against a memory with random wait states.
// tb_checker compares the stores that appear on the bus.
`default_nettype none

module tb_cpu16;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'he644_71ec;
	localparam int MAX_WAIT = 6;  // Longest run of ready low
	localparam int DRAIN    = 40; // Idle cycles after the last store, to catch extras

	logic             CLK = 1'b0;
	logic             RSTb = 1'b0;
	logic             rready = 1'b0;
	logic             wready = 1'b0;
	logic             rvalid;
	logic             wvalid;
	cpu16_pkg::word_t mem_addr;
	cpu16_pkg::word_t mem_wdata;
	cpu16_pkg::word_t mem_rdata;
	cpu16_pkg::word_t mem [65536];
	cpu16_pkg::word_t prog [256];
	cpu16_pkg::word_t exp_addr [64];
	cpu16_pkg::word_t exp_data [64];
	int               prog_len = 0;
	int               exp_cnt = 0;
	int               rready_pct = 100;
	int               wready_pct = 100;
	int               rlow = 0;
	int               wlow = 0;
	int               cycles = 0;
	int               cycle_limit = 0;
	int               got_count;
	int               tests_run;
	int               tests_failed;
	logic             r_hit;
	logic             w_hit;
	logic [31:0]      prog_seed = SEED;
	logic [31:0]      bus_seed = ~SEED;

	always #10 CLK = ~CLK;

	cpu16_top i_dut (
		.CLK(CLK), .RSTb(RSTb), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .rvalid(rvalid), .rready(rready),
		.wvalid(wvalid), .wready(wready)
	);

	tb_checker i_checker (
		.CLK(CLK), .RSTb(RSTb), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.rvalid(rvalid), .wvalid(wvalid), .wready(wready),
		.got_count(got_count), .tests_run(tests_run), .tests_failed(tests_failed)
	);

	assign mem_rdata = mem[mem_addr]; // Read data is there in the cycle of the request

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu16_pkg::word_t rand_word();
		prog_seed = lcg_next(prog_seed);
		return prog_seed[31:16];
	endfunction

	// Ready lines redrawn every cycle, with a cap on the wait
	always @(posedge CLK) begin
		bus_seed = lcg_next(bus_seed);
		r_hit = (int'(bus_seed[31:16]) % 100 < rready_pct) || (rlow >= MAX_WAIT);
		bus_seed = lcg_next(bus_seed);
		w_hit = (int'(bus_seed[31:16]) % 100 < wready_pct) || (wlow >= MAX_WAIT);
		rlow = r_hit ? 0 : rlow + 1;
		wlow = w_hit ? 0 : wlow + 1;
		rready <= r_hit;
		wready <= w_hit;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the expected stores never completed", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic cpu16_pkg::word_t alu_ref(input logic [2:0] op,
		input cpu16_pkg::word_t a, input cpu16_pkg::word_t b);
		case (op)
			3'd0: return b;
			3'd1: return a + b;
			3'd2: return a - b;
			3'd3: return a & b;
			3'd4: return a | b;
			3'd5: return a ^ b;
			3'd6: return a << b[3:0];
			default: return a >> b[3:0];
		endcase
	endfunction

	// Steps the program in order; each result lands one instruction late
	function automatic int model_program();
		cpu16_pkg::word_t regs [16];
		cpu16_pkg::word_t ins;
		cpu16_pkg::word_t a;
		cpu16_pkg::word_t b;
		cpu16_pkg::word_t imm;
		cpu16_pkg::word_t res;
		logic [11:0]      prefix;
		logic [3:0]       pend_reg;
		cpu16_pkg::word_t pend_val;
		logic             pend_en;
		logic             now_en;
		int               n;
		n = 0;
		prefix = '0;
		pend_en = 1'b0;
		pend_reg = '0;
		pend_val = '0;
		for (int r = 0; r < 16; r++)
			regs[r] = '0;
		for (int i = 0; i < prog_len; i++) begin
			ins = prog[i];
			a = regs[ins[7:4]];
			b = regs[ins[3:0]];
			imm = {prefix, ins[3:0]};
			res = '0;
			now_en = 1'b1;
			case (ins[15:12])
				4'h2: res = alu_ref(ins[10:8], a, b);
				4'h3: res = alu_ref(ins[10:8], a, imm);
				4'h6: begin
					res = mem[imm];
					now_en = !ins[8];
					if (ins[8]) begin
						exp_addr[n] = imm;
						exp_data[n] = a;
						n++;
					end
				end
				default: now_en = 1'b0;
			endcase
			if (ins[15:12] == 4'h1)
				prefix = ins[11:0];
			else if (ins != 16'h0000)
				prefix = '0;
			if (pend_en)
				regs[pend_reg] = pend_val;
			pend_en = now_en;
			pend_reg = ins[7:4];
			pend_val = res;
		end
		return n;
	endfunction

	task automatic emit(input cpu16_pkg::word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Prefix plus mov-immediate gives a full 16-bit constant
	task automatic emit_const(input logic [3:0] r, input cpu16_pkg::word_t v);
		emit({4'h1, v[15:4]});
		emit({8'h30, r, v[3:0]});
	endtask

	task automatic emit_mem(input logic store, input logic [3:0] r, input cpu16_pkg::word_t a);
		emit({4'h1, a[15:4]});
		emit({7'b0110_000, store, r, a[3:0]});
	endtask

	task automatic build_program(input int kind);
		cpu16_pkg::word_t v;
		case (kind)
			0: begin // Reset and a single store
				emit_const(4'd1, 16'ha5c3);
				emit(16'h0000);
				emit_mem(1'b1, 4'd1, 16'h9000);
			end
			1: begin // All eight ALU ops, register-register
				emit_const(4'd1, rand_word());
				emit_const(4'd2, rand_word());
				for (int op = 0; op < 8; op++) begin
					v = rand_word();
					emit({8'h20, 4'(8 + op), 4'h1});
					emit(16'h0000);
					emit({4'h2, v[0], 3'(op), 4'(8 + op), 4'h2}); // ins[11] is random
				end
				for (int op = 0; op < 8; op++)
					emit_mem(1'b1, 4'(8 + op), 16'h9000 + 16'(op));
			end
			2: begin // Immediates with and without prefix
				for (int k = 0; k < 4; k++) begin
					v = rand_word();
					emit({8'h30, 4'(k + 1), v[3:0]});
					emit_const(4'(k + 5), v);
					emit({4'h1, v[15:4]});
					emit({8'h31, 4'(k + 1), v[3:0]});
				end
				for (int k = 0; k < 8; k++)
					emit_mem(1'b1, 4'(k + 1), 16'h9100 + 16'(k));
			end
			3: begin // Distance one and two
				emit_const(4'd1, rand_word());
				emit_const(4'd2, rand_word());
				emit(16'h0000);
				emit(16'h2112);
				emit(16'h2031);
				emit(16'h2041);
				for (int k = 0; k < 4; k++)
					emit(16'h3151);
				emit(16'h0000);
				for (int k = 1; k < 6; k++)
					emit_mem(1'b1, 4'(k), 16'h9200 + 16'(k));
			end
			4: begin // Loads from the data area
				for (int k = 0; k < 8; k++) begin
					v = rand_word();
					emit_mem(1'b0, 4'(k + 1), {12'h800, v[3:0]});
				end
				emit(16'h0000);
				for (int k = 0; k < 4; k++)
					emit({8'h21, 4'(k + 1), 4'(k + 5)});
				emit(16'h0000);
				for (int k = 0; k < 8; k++)
					emit_mem(1'b1, 4'(k + 1), 16'h9300 + 16'(k));
			end
			default: begin // Stores to random addresses
				for (int k = 0; k < 6; k++)
					emit_const(4'(k + 1), rand_word());
				for (int k = 0; k < 6; k++) begin
					v = rand_word();
					emit_mem(1'b1, 4'(k + 1), {4'h9, v[11:0]});
				end
			end
		endcase
	endtask

	task automatic run_test(input string name, input int kind, input int rpct, input int wpct);
		@(posedge CLK);
		RSTb <= 1'b0;
		@(negedge CLK);
		rready_pct = rpct;
		wready_pct = wpct;
		if (kind == 4)
			prog_seed = SEED; // Same loads and data in both runs
		for (int d = 0; d < 16; d++)
			mem[16'h8000 + 16'(d)] = rand_word();
		prog_len = 0;
		build_program(kind);
		for (int a = 0; a < 256; a++)
			mem[a] = (a < prog_len) ? prog[a] : 16'h0000;
		exp_cnt = model_program();
		cycle_limit = cycles + (prog_len + 8) * 2 * (MAX_WAIT + 2) + 10 + DRAIN + 20;
		i_checker.start_test(name);
		for (int k = 0; k < exp_cnt; k++)
			i_checker.add_expected(exp_addr[k], exp_data[k]);
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		while (got_count < exp_cnt)
			@(negedge CLK);
		repeat (DRAIN) @(negedge CLK);
		i_checker.finish_test();
	endtask

	initial begin
		run_test("reset", 0, 100, 100);
		run_test("alu_rr", 1, 80, 80);
		run_test("imm_prefix", 2, 70, 70);
		run_test("hazard", 3, 100, 100);
		run_test("loads_fast", 4, 100, 100);
		run_test("loads_slow", 4, 15, 100);
		run_test("stores", 5, 70, 40);
		$display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
		if (tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
// Watches the core's bus. Checks strobes in reset and the first fetch address,
// compares each completed write against the expected store list and keeps counts.
`default_nettype none

module tb_checker (
	input  wire                   CLK,
	input  wire                   RSTb,
	input  wire cpu16_pkg::word_t mem_addr,
	input  wire cpu16_pkg::word_t mem_wdata,
	input  wire                   rvalid,
	input  wire                   wvalid,
	input  wire                   wready,
	output int                    got_count,
	output int                    tests_run,
	output int                    tests_failed
);
	timeunit 1ns;
	timeprecision 1ps;

	string            test_name;
	cpu16_pkg::word_t want_addr [$];
	cpu16_pkg::word_t want_data [$];
	int               errors = 0;
	logic             rst_seen = 1'b0;
	logic             first_fetch = 1'b0;

	task automatic start_test(input string name);
		test_name = name;
		want_addr.delete();
		want_data.delete();
		errors = 0;
	endtask

	task automatic add_expected(input cpu16_pkg::word_t a, input cpu16_pkg::word_t d);
		want_addr.push_back(a);
		want_data.push_back(d);
	endtask

	always @(posedge CLK) begin
		if (!RSTb) begin
			if (rst_seen && (rvalid || wvalid)) begin
				$display("%s: bus strobe active while in reset", test_name);
				errors++;
			end
			rst_seen = 1'b1;
			first_fetch = 1'b1;
			got_count = 0;
		end else begin
			rst_seen = 1'b0;
			if (first_fetch && rvalid) begin
				if (mem_addr !== 16'h0000) begin
					$display("ERR %s first fetch: expected 0000 actual %h", test_name, mem_addr);
					errors++;
				end
				first_fetch = 1'b0;
			end
			if (wvalid && wready) begin
				if (got_count < want_addr.size()) begin
					if (mem_addr !== want_addr[got_count] ||
						mem_wdata !== want_data[got_count]) begin
						$display("ERR %s store %0d: expected %h at %h, actual %h at %h",
							test_name, got_count, want_data[got_count],
							want_addr[got_count], mem_wdata, mem_addr);
						errors++;
					end
				end
				got_count++;
			end
		end
	end

	task automatic finish_test();
		logic failed;
		failed = (errors != 0);
		if (got_count < want_addr.size()) begin
			$display("%s: only %0d of %0d stores were seen", test_name, got_count,
				want_addr.size());
			failed = 1'b1;
		end else if (got_count > want_addr.size()) begin
			$display("%s: %0d stores seen but only %0d expected", test_name, got_count,
				want_addr.size());
			failed = 1'b1;
		end
		tests_run++;
		if (failed) begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", test_name, errors);
		end else begin
			$display("PASS %s (%0d stores)", test_name, got_count);
		end
	endtask

endmodule

`default_nettype wire

// ==== cpu16_top.sv ====
// Top of the 16-bit core: chains fetch, decode, execute and write-back around
// the register file, makes the common advance strobe and shares one memory bus
// between instruction fetch and data access.
`default_nettype none

module cpu16_top (
	input  wire               CLK,
	input  wire               RSTb,
	output cpu16_pkg::word_t  mem_addr,
	output cpu16_pkg::word_t  mem_wdata,
	input  cpu16_pkg::word_t  mem_rdata,
	output logic              rvalid,
	input  wire               rready,
	output logic              wvalid,
	input  wire               wready
);

	logic                 advance;
	logic                 mem_busy;
	logic                 fetch_req;
	cpu16_pkg::word_t     fetch_addr;
	cpu16_pkg::word_t     instr_f;
	logic                 valid_f;
	cpu16_pkg::reg_addr_t rd_addr_a;
	cpu16_pkg::reg_addr_t rd_addr_b;
	cpu16_pkg::word_t     rd_data_a;
	cpu16_pkg::word_t     rd_data_b;
	cpu16_pkg::word_t     instr_d;
	cpu16_pkg::word_t     operand_a;
	cpu16_pkg::word_t     operand_b;
	cpu16_pkg::word_t     imm_d;
	logic                 valid_d;
	cpu16_pkg::word_t     instr_e;
	cpu16_pkg::word_t     result_e;
	cpu16_pkg::word_t     store_data_e;
	logic                 valid_e;
	cpu16_pkg::word_t     data_addr;
	logic                 data_rvalid;
	logic                 data_wvalid;
	logic                 wr_en;
	cpu16_pkg::reg_addr_t wr_addr;
	cpu16_pkg::word_t     wr_data;

	// Every stage moves together once the fetched word is in
	assign advance = fetch_req && rready && !mem_busy;

	// Bus goes to write-back while it holds a memory instruction
	assign mem_addr = mem_busy ? data_addr : fetch_addr;
	assign rvalid   = fetch_req || data_rvalid;
	assign wvalid   = data_wvalid;

	fetch_stage i_fetch (
		.CLK(CLK), .RSTb(RSTb), .advance(advance), .bus_grant(!mem_busy),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .mem_rdata(mem_rdata),
		.instr_f(instr_f), .valid_f(valid_f)
	);

	decode_stage i_decode (
		.CLK(CLK), .RSTb(RSTb), .advance(advance), .instr_f(instr_f), .valid_f(valid_f),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.instr_d(instr_d), .operand_a(operand_a), .operand_b(operand_b),
		.imm_d(imm_d), .valid_d(valid_d)
	);

	reg_file i_regs (
		.CLK(CLK), .RSTb(RSTb), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	execute_stage i_execute (
		.CLK(CLK), .RSTb(RSTb), .advance(advance), .instr_d(instr_d),
		.operand_a(operand_a), .operand_b(operand_b), .imm_d(imm_d), .valid_d(valid_d),
		.instr_e(instr_e), .result_e(result_e), .store_data_e(store_data_e),
		.valid_e(valid_e)
	);

	writeback_stage i_writeback (
		.CLK(CLK), .RSTb(RSTb), .instr_e(instr_e), .result_e(result_e),
		.store_data_e(store_data_e), .valid_e(valid_e), .mem_busy(mem_busy),
		.data_addr(data_addr), .data_wdata(mem_wdata),
		.data_rvalid(data_rvalid), .data_wvalid(data_wvalid),
		.mem_rdata(mem_rdata), .rready(rready), .wready(wready),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
// Write-back stage: writes ALU results to the register file and runs loads and
// stores on the shared bus. mem_busy keeps the pipeline frozen while an access
// is outstanding.
`default_nettype none

module writeback_stage (
	input  wire                   CLK,
	input  wire                   RSTb,
	input  cpu16_pkg::word_t      instr_e,
	input  cpu16_pkg::word_t      result_e,
	input  cpu16_pkg::word_t      store_data_e,
	input  wire                   valid_e,
	output logic                  mem_busy,
	output cpu16_pkg::word_t      data_addr,
	output cpu16_pkg::word_t      data_wdata,
	output logic                  data_rvalid,
	output logic                  data_wvalid,
	input  cpu16_pkg::word_t      mem_rdata,
	input  wire                   rready,
	input  wire                   wready,
	output logic                  wr_en,
	output cpu16_pkg::reg_addr_t  wr_addr,
	output cpu16_pkg::word_t      wr_data
);

	cpu16_pkg::wb_state_t state;
	logic                 done;   // Access for the current instr_e is finished
	logic                 is_mem;
	logic                 is_alu;
	logic                 mem_pending;

	assign is_mem = valid_e && (instr_e[15:12] == cpu16_pkg::OPC_MEM);
	assign is_alu = valid_e && (instr_e[15:12] == cpu16_pkg::OPC_ALU_RR ||
		instr_e[15:12] == cpu16_pkg::OPC_ALU_RI);
	assign mem_pending = is_mem && !done && (state == cpu16_pkg::idle);

	assign mem_busy    = mem_pending || (state != cpu16_pkg::idle);
	assign data_addr   = result_e;
	assign data_wdata  = store_data_e;
	assign data_rvalid = (state == cpu16_pkg::wait_rd);
	assign data_wvalid = (state == cpu16_pkg::wait_wr);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= cpu16_pkg::idle;
			done  <= 1'b0;
		end else begin
			case (state)
				cpu16_pkg::idle:
					if (mem_pending)
						state <= instr_e[8] ? cpu16_pkg::wait_wr : cpu16_pkg::wait_rd;
					else if (rready)
						done <= 1'b0; // Fetch owns the bus here, so rready moves the pipe
				cpu16_pkg::wait_rd:
					if (rready) begin
						state <= cpu16_pkg::idle;
						done  <= 1'b1;
					end
				cpu16_pkg::wait_wr:
					if (wready) begin
						state <= cpu16_pkg::idle;
						done  <= 1'b1;
					end
				default: state <= cpu16_pkg::idle;
			endcase
		end
	end

	// Loads write when their data arrives, ALU results while idle
	assign wr_addr = instr_e[7:4];
	assign wr_en   = (data_rvalid && rready) || (is_alu && state == cpu16_pkg::idle);
	assign wr_data = data_rvalid ? mem_rdata : result_e;

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// Execute stage: chooses operand B, runs the eight-operation ALU and registers
// the result for write-back. Memory instructions pass their address and store
// data through instead.
`default_nettype none

module execute_stage (
	input  wire               CLK,
	input  wire               RSTb,
	input  wire               advance,
	input  cpu16_pkg::word_t  instr_d,
	input  cpu16_pkg::word_t  operand_a,
	input  cpu16_pkg::word_t  operand_b,
	input  cpu16_pkg::word_t  imm_d,
	input  wire               valid_d,
	output cpu16_pkg::word_t  instr_e,
	output cpu16_pkg::word_t  result_e,
	output cpu16_pkg::word_t  store_data_e,
	output logic              valid_e
);

	logic [3:0]         opcode;
	cpu16_pkg::alu_op_t alu_op;
	cpu16_pkg::word_t   alu_b;
	cpu16_pkg::word_t   alu_out;

	assign opcode = instr_d[15:12];
	assign alu_op = instr_d[10:8]; // ins[11] is not part of the op

	// Register-immediate form swaps in the immediate
	assign alu_b = (opcode == cpu16_pkg::OPC_ALU_RI) ? imm_d : operand_b;

	always_comb begin
		case (alu_op)
			cpu16_pkg::ALU_MOV: alu_out = alu_b;
			cpu16_pkg::ALU_ADD: alu_out = operand_a + alu_b;
			cpu16_pkg::ALU_SUB: alu_out = operand_a - alu_b;
			cpu16_pkg::ALU_AND: alu_out = operand_a & alu_b;
			cpu16_pkg::ALU_OR:  alu_out = operand_a | alu_b;
			cpu16_pkg::ALU_XOR: alu_out = operand_a ^ alu_b;
			cpu16_pkg::ALU_SHL: alu_out = operand_a << alu_b[3:0];
			default:            alu_out = operand_a >> alu_b[3:0]; // ALU_SHR
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			instr_e <= cpu16_pkg::NOP_INSTRUCTION;
			valid_e <= 1'b0;
		end else if (advance) begin
			instr_e <= instr_d;
			valid_e <= valid_d;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance) begin
			// For 6xxx the result is the data address
			result_e     <= (opcode == cpu16_pkg::OPC_MEM) ? imm_d : alu_out;
			store_data_e <= operand_a;
		end
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// Sixteen 16-bit registers, one write port and two read ports.
// A read of the register being written returns the new value in the same cycle.
`default_nettype none

module reg_file (
	input  wire                   CLK,
	input  wire                   RSTb,
	input  cpu16_pkg::reg_addr_t  rd_addr_a,
	input  cpu16_pkg::reg_addr_t  rd_addr_b,
	output cpu16_pkg::word_t      rd_data_a,
	output cpu16_pkg::word_t      rd_data_b,
	input  wire                   wr_en,
	input  cpu16_pkg::reg_addr_t  wr_addr,
	input  cpu16_pkg::word_t      wr_data
);

	cpu16_pkg::word_t regs [cpu16_pkg::NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < cpu16_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through bypass
	assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// Decode stage: picks the register read addresses for the fetched word, keeps
// the 12-bit immediate prefix and registers instruction, operands and
// immediate for execute on each advance.
`default_nettype none

module decode_stage (
	input  wire                   CLK,
	input  wire                   RSTb,
	input  wire                   advance,
	input  cpu16_pkg::word_t      instr_f,
	input  wire                   valid_f,
	output cpu16_pkg::reg_addr_t  rd_addr_a,
	output cpu16_pkg::reg_addr_t  rd_addr_b,
	input  cpu16_pkg::word_t      rd_data_a,
	input  cpu16_pkg::word_t      rd_data_b,
	output cpu16_pkg::word_t      instr_d,
	output cpu16_pkg::word_t      operand_a,
	output cpu16_pkg::word_t      operand_b,
	output cpu16_pkg::word_t      imm_d,
	output logic                  valid_d
);

	logic [3:0]         opcode;
	cpu16_pkg::imm_hi_t imm_prefix;
	logic               is_prefix;
	logic               is_nop;

	assign opcode    = instr_f[15:12];
	assign is_prefix = (opcode == cpu16_pkg::OPC_IMM);
	assign is_nop    = (instr_f == cpu16_pkg::NOP_INSTRUCTION);

	// Register A is the destination / store source, B the second source
	always_comb begin
		rd_addr_a = '0;
		rd_addr_b = '0;
		case (opcode)
			cpu16_pkg::OPC_ALU_RR: begin
				rd_addr_a = instr_f[7:4];
				rd_addr_b = instr_f[3:0];
			end
			cpu16_pkg::OPC_ALU_RI,
			cpu16_pkg::OPC_MEM: begin
				rd_addr_a = instr_f[7:4];
			end
			default: ;
		endcase
	end

	// Prefix is loaded by 1xxx and used up by the next real instruction
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_prefix <= '0;
		end else if (advance) begin
			if (is_prefix)
				imm_prefix <= instr_f[11:0];
			else if (!is_nop)
				imm_prefix <= '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			instr_d <= cpu16_pkg::NOP_INSTRUCTION;
			valid_d <= 1'b0;
		end else if (advance) begin
			instr_d <= instr_f;
			valid_d <= valid_f;
		end
	end

	// Operands and immediate are payload only
	always_ff @(posedge CLK) begin
		if (advance) begin
			operand_a <= rd_data_a;
			operand_b <= rd_data_b;
			imm_d     <= {imm_prefix, instr_f[3:0]};
		end
	end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// Instruction fetch: holds the PC, asks the shared bus for the word at the PC
// and captures it into the decode-side register on each pipeline advance.
`default_nettype none

module fetch_stage (
	input  wire               CLK,
	input  wire               RSTb,
	input  wire               advance,
	input  wire               bus_grant,  // Write-back is not using the bus
	output logic              fetch_req,
	output cpu16_pkg::word_t  fetch_addr,
	input  cpu16_pkg::word_t  mem_rdata,
	output cpu16_pkg::word_t  instr_f,
	output logic              valid_f
);

	cpu16_pkg::word_t pc;
	logic             running; // Low only in the cycle that leaves reset

	// Bus request follows the PC, nothing is latched for it
	assign fetch_req  = bus_grant & running;
	assign fetch_addr = pc;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc      <= '0;
			instr_f <= cpu16_pkg::NOP_INSTRUCTION;
			valid_f <= 1'b0;
		end else if (advance) begin
			instr_f <= mem_rdata; // Read data is valid with rready
			valid_f <= 1'b1;
			pc      <= pc + 16'd1;
		end
	end

endmodule

`default_nettype wire

// ==== cpu16_pkg.sv ====
// Shared widths, opcodes, ALU codes and state encodings for the 16-bit pipelined core.
// Every RTL file refers to these by scoped name, cpu16_pkg::name.
`default_nettype none

package cpu16_pkg;

	localparam int WORD_W   = 16;
	localparam int REG_AW   = 4;
	localparam int IMM_HI_W = 12;
	localparam int ALU_OP_W = 3;
	localparam int NUM_REGS = 16;

	typedef logic [WORD_W-1:0]   word_t;     // Data, address and instruction word
	typedef logic [REG_AW-1:0]   reg_addr_t; // Register index
	typedef logic [IMM_HI_W-1:0] imm_hi_t;   // Upper immediate from a 1xxx prefix
	typedef logic [ALU_OP_W-1:0] alu_op_t;

	localparam word_t NOP_INSTRUCTION = '0;

	// Top nibble of the instruction, anything else behaves as a nop
	localparam logic [3:0] OPC_IMM    = 4'h1;
	localparam logic [3:0] OPC_ALU_RR = 4'h2;
	localparam logic [3:0] OPC_ALU_RI = 4'h3;
	localparam logic [3:0] OPC_MEM    = 4'h6;

	// ALU operations, taken from ins[10:8]
	localparam alu_op_t ALU_MOV = 3'd0; // Passes operand B
	localparam alu_op_t ALU_ADD = 3'd1;
	localparam alu_op_t ALU_SUB = 3'd2; // A - B
	localparam alu_op_t ALU_AND = 3'd3;
	localparam alu_op_t ALU_OR  = 3'd4;
	localparam alu_op_t ALU_XOR = 3'd5;
	localparam alu_op_t ALU_SHL = 3'd6; // Shift amount is B[3:0]
	localparam alu_op_t ALU_SHR = 3'd7; // Logical

	// Write-back bus access state
	typedef enum logic [1:0] {
		idle,
		wait_rd,
		wait_wr
	} wb_state_t;

endpackage

`default_nettype wire
